//--- source/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

    // cache geometry
    localparam int NUM_WAYS       = 4;
    localparam int WORDS_PER_LINE = 4;
    localparam int LINE_BITS      = 128;

    // load size codes carried on write_type
    localparam logic [3:0] SIZE_BYTE = 4'b0001;
    localparam logic [3:0] SIZE_HALF = 4'b0011;
    localparam logic [3:0] SIZE_WORD = 4'b1111;

    // one data word, seen whole or as byte lanes
    typedef union packed {
        logic [31:0]     w;
        logic [3:0][7:0] b;
    } word_t;

    // word 0 sits in the low bits
    typedef word_t [WORDS_PER_LINE-1:0] line_t;

    typedef logic [NUM_WAYS-1:0] way_mask_t;

endpackage

`default_nettype wire

//--- source/dcache_way_if.sv
`default_nettype none

interface dcache_way_if #(
    parameter int SETS_LOG2 = 6
);
    import dcache_pkg::*;

    localparam int TAG_W = 32 - SETS_LOG2 - 4;

    // lookup address
    logic [SETS_LOG2-1:0]      index;
    logic [TAG_W-1:0]          tag;

    // write side
    logic [WORDS_PER_LINE-1:0] we;
    line_t                     wdata;
    logic                      tag_we;
    logic                      dirty_we;
    logic                      dirty_wdata;

    // registered results of the last read
    logic                      hit;
    logic                      valid;
    logic                      dirty;
    logic [TAG_W-1:0]          rtag;
    line_t                     rdata;

    modport req (output index, tag);

    modport ctrl (
        output we, wdata, tag_we, dirty_we, dirty_wdata,
        input  hit, valid, dirty, rtag, rdata
    );

    modport way (
        input  index, tag, we, wdata, tag_we, dirty_we, dirty_wdata,
        output hit, valid, dirty, rtag, rdata
    );

endinterface

`default_nettype wire

//--- source/dcache_req_buf.sv
`default_nettype none

module dcache_req_buf #(
    parameter int SETS_LOG2 = 6
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              accept,
    input  logic [31:0]       addr,
    input  logic              op,
    input  logic [3:0]        write_type,
    input  dcache_pkg::word_t w_data_cpu,
    input  logic              signed_ext,
    input  dcache_pkg::word_t hit_word,
    output logic [31:0]       addr_q,
    output logic              op_q,
    output logic [3:0]        write_type_q,
    output logic              signed_ext_q,
    output dcache_pkg::word_t store_word,
    dcache_way_if.req         ways [dcache_pkg::NUM_WAYS]
);
    import dcache_pkg::*;

    localparam int TAG_W = 32 - SETS_LOG2 - 4;

    word_t       w_data_q;
    logic [31:0] look_addr;

    always_ff @(posedge clk) begin
        if (rst) begin
            op_q <= 1'b0;
        end else if (accept) begin
            op_q <= op;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q       <= addr;
            write_type_q <= write_type;
            signed_ext_q <= signed_ext;
            w_data_q     <= w_data_cpu;
        end
    end

    // live address on the accept cycle so the ways start reading at once
    assign look_addr = accept ? addr : addr_q;

    for (genvar g = 0; g < NUM_WAYS; g++) begin : g_way_addr
        assign ways[g].index = look_addr[4 +: SETS_LOG2];
        assign ways[g].tag   = look_addr[31 -: TAG_W];
    end

    // store bytes over the word currently held in the hit way
    always_comb begin
        store_word = hit_word;
        for (int i = 0; i < 4; i++) begin
            if (write_type_q[i]) begin
                store_word.b[i] = w_data_q.b[i];
            end
        end
    end

    a_store_mask: assert property (@(posedge clk) disable iff (rst)
        accept && op |=> write_type_q != 4'b0000);

endmodule

`default_nettype wire

//--- source/dcache_way.sv
`default_nettype none

module dcache_way #(
    parameter int SETS_LOG2 = 6
) (
    input  logic      clk,
    input  logic      rst,
    dcache_way_if.way wif
);
    import dcache_pkg::*;

    localparam int SETS  = 1 << SETS_LOG2;
    localparam int TAG_W = 32 - SETS_LOG2 - 4;

    logic [TAG_W-1:0]     tag_mem [SETS];
    word_t                data_mem [WORDS_PER_LINE][SETS];
    logic [SETS-1:0]      valid_bits;
    logic [SETS-1:0]      dirty_bits;

    logic [SETS_LOG2-1:0] clr_idx;
    logic                 clr_busy;
    logic                 swept;

    logic [TAG_W-1:0]     rtag_q;
    logic [TAG_W-1:0]     cmp_tag_q;
    logic                 valid_q;
    logic                 dirty_q;
    line_t                rdata_q;

    // sets the sweep has not reached yet read as invalid
    assign swept = !clr_busy || (wif.index < clr_idx);

    always_ff @(posedge clk) begin
        if (rst) begin
            clr_busy <= 1'b1;
            clr_idx  <= '0;
            valid_q  <= 1'b0;
        end else begin
            if (clr_busy) begin
                valid_bits[clr_idx] <= 1'b0;
                clr_idx             <= clr_idx + 1'b1;
                if (&clr_idx) begin
                    clr_busy <= 1'b0;
                end
            end
            if (wif.tag_we) begin
                valid_bits[wif.index] <= 1'b1;
            end
            valid_q <= valid_bits[wif.index] && swept;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < WORDS_PER_LINE; i++) begin
            if (wif.we[i]) begin
                data_mem[i][wif.index] <= wif.wdata[i];
            end
            rdata_q[i] <= data_mem[i][wif.index];
        end
        if (wif.tag_we) begin
            tag_mem[wif.index] <= wif.tag;
        end
        if (wif.dirty_we) begin
            dirty_bits[wif.index] <= wif.dirty_wdata;
        end
        rtag_q    <= tag_mem[wif.index];
        dirty_q   <= dirty_bits[wif.index];
        cmp_tag_q <= wif.tag;
    end

    assign wif.hit   = valid_q && (rtag_q == cmp_tag_q);
    assign wif.valid = valid_q;
    assign wif.dirty = dirty_q;
    assign wif.rtag  = rtag_q;
    assign wif.rdata = rdata_q;

    // a new tag always installs a whole line
    a_tag_full_line: assert property (@(posedge clk) disable iff (rst)
        wif.tag_we |-> &wif.we);

endmodule

`default_nettype wire

//--- source/dcache_ctrl.sv
`default_nettype none

module dcache_ctrl #(
    parameter int SETS_LOG2 = 6
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              valid,
    input  logic [31:0]       addr_q,
    input  logic              op_q,
    input  logic [3:0]        write_type_q,
    input  logic              signed_ext_q,
    input  dcache_pkg::word_t store_word,
    input  logic              r_rdy,
    input  logic              ret_valid,
    input  logic              ret_last,
    input  logic [31:0]       r_data_mem,
    input  logic              w_rdy,
    input  logic              w_data_ready,
    output logic              accept,
    output dcache_pkg::word_t hit_word,
    output logic              cache_ready,
    output logic              data_valid,
    output logic [31:0]       r_data_cpu,
    output logic              r_req,
    output logic [31:0]       r_addr,
    output logic              r_data_ready,
    output logic              w_req,
    output logic [31:0]       w_addr,
    output logic              w_data_req,
    output logic              w_last,
    output logic [31:0]       w_data_mem,
    dcache_way_if.ctrl        ways [dcache_pkg::NUM_WAYS]
);
    import dcache_pkg::*;

    localparam int SETS  = 1 << SETS_LOG2;
    localparam int TAG_W = 32 - SETS_LOG2 - 4;

    localparam logic [3:0] S_IDLE    = 4'd0;
    localparam logic [3:0] S_READ    = 4'd1;
    localparam logic [3:0] S_LOOKUP  = 4'd2;
    localparam logic [3:0] S_WB_REQ  = 4'd3;
    localparam logic [3:0] S_WB_DATA = 4'd4;
    localparam logic [3:0] S_RF_REQ  = 4'd5;
    localparam logic [3:0] S_RF_COLL = 4'd6;
    localparam logic [3:0] S_INSTALL = 4'd7;
    localparam logic [3:0] S_DONE    = 4'd8;

    logic [3:0]           state;
    logic [3:0]           state_nxt;
    logic [SETS_LOG2-1:0] set_idx;
    logic [1:0]           word_off;
    logic                 lookup_hit;

    way_mask_t            hits;
    way_mask_t            vlds;
    way_mask_t            dirts;
    line_t                way_line [NUM_WAYS];
    logic [TAG_W-1:0]     way_tag [NUM_WAYS];

    line_t                hit_line;
    way_mask_t            victim_c;
    way_mask_t            victim_q;
    logic                 victim_dirty;
    line_t                vic_line;
    logic [TAG_W-1:0]     vic_tag;

    logic [2:0]           plru_mem [SETS];
    logic [2:0]           plru_cur;
    logic [1:0]           plru_way;
    logic                 plru_upd;
    logic [1:0]           touch_idx;

    line_t                fill_line;
    logic [1:0]           wb_cnt;
    word_t                load_word;
    logic [7:0]           byte_v;
    logic [15:0]          half_v;

    logic [WORDS_PER_LINE-1:0] we_c;
    line_t                wdata_c;
    way_mask_t            wsel;
    logic                 tag_we_c;
    logic                 dirty_we_c;
    logic                 dirty_val_c;

    function automatic logic [1:0] way_enc(input way_mask_t m);
        logic [1:0] idx;
        idx = '0;
        for (int i = 0; i < NUM_WAYS; i++) begin
            if (m[i]) begin
                idx = 2'(i);
            end
        end
        return idx;
    endfunction

    for (genvar g = 0; g < NUM_WAYS; g++) begin : g_way_io
        assign hits[g]     = ways[g].hit;
        assign vlds[g]     = ways[g].valid;
        assign dirts[g]    = ways[g].dirty;
        assign way_line[g] = ways[g].rdata;
        assign way_tag[g]  = ways[g].rtag;

        assign ways[g].we          = wsel[g] ? we_c : '0;
        assign ways[g].wdata       = wdata_c;
        assign ways[g].tag_we      = wsel[g] && tag_we_c;
        assign ways[g].dirty_we    = wsel[g] && dirty_we_c;
        assign ways[g].dirty_wdata = dirty_val_c;
    end

    assign set_idx    = addr_q[4 +: SETS_LOG2];
    assign word_off   = addr_q[3:2];
    assign lookup_hit = (state == S_LOOKUP) && (|hits);

    always_comb begin
        hit_line = '0;
        vic_line = '0;
        vic_tag  = '0;
        for (int i = 0; i < NUM_WAYS; i++) begin
            if (hits[i]) begin
                hit_line = hit_line | way_line[i];
            end
            if (victim_q[i]) begin
                vic_line = vic_line | way_line[i];
                vic_tag  = vic_tag | way_tag[i];
            end
        end
    end

    assign hit_word = hit_line[word_off];

    // tree bits point at the side to evict next
    assign plru_cur = plru_mem[set_idx];
    assign plru_way = plru_cur[0] ? {1'b1, plru_cur[2]} : {1'b0, plru_cur[1]};

    always_comb begin
        victim_c           = '0;
        victim_c[plru_way] = 1'b1;
        for (int i = NUM_WAYS - 1; i >= 0; i--) begin
            if (!vlds[i]) begin
                victim_c    = '0;
                victim_c[i] = 1'b1;
            end
        end
    end

    assign victim_dirty = |(victim_c & vlds & dirts);

    always_comb begin
        state_nxt = state;
        case (state)
            S_IDLE:    if (valid) state_nxt = S_READ;
            S_READ:    state_nxt = S_LOOKUP;
            S_LOOKUP: begin
                if (|hits) begin
                    state_nxt = S_DONE;
                end else if (victim_dirty) begin
                    state_nxt = S_WB_REQ;
                end else begin
                    state_nxt = S_RF_REQ;
                end
            end
            S_WB_REQ:  if (w_rdy) state_nxt = S_WB_DATA;
            S_WB_DATA: if (w_data_ready && wb_cnt == 2'd3) state_nxt = S_RF_REQ;
            S_RF_REQ:  if (r_rdy) state_nxt = S_RF_COLL;
            S_RF_COLL: if (ret_valid && ret_last) state_nxt = S_INSTALL;
            // replay the access against the new line
            S_INSTALL: state_nxt = S_READ;
            default:   state_nxt = S_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= S_IDLE;
            data_valid <= 1'b0;
            wb_cnt     <= '0;
        end else begin
            state      <= state_nxt;
            data_valid <= lookup_hit;
            if (state == S_WB_DATA && w_data_ready) begin
                wb_cnt <= wb_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_LOOKUP && !(|hits)) begin
            victim_q <= victim_c;
        end
        if (state == S_RF_COLL && ret_valid) begin
            fill_line <= line_t'(LINE_BITS'({r_data_mem, fill_line} >> 32));
        end
        if (lookup_hit) begin
            r_data_cpu <= load_word.w;
        end
    end

    assign plru_upd  = lookup_hit || (state == S_INSTALL);
    assign touch_idx = (state == S_INSTALL) ? way_enc(victim_q) : way_enc(hits);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < SETS; s++) begin
                plru_mem[s] <= '0;
            end
        end else if (plru_upd) begin
            plru_mem[set_idx][0] <= ~touch_idx[1];
            if (touch_idx[1]) begin
                plru_mem[set_idx][2] <= ~touch_idx[0];
            end else begin
                plru_mem[set_idx][1] <= ~touch_idx[0];
            end
        end
    end

    always_comb begin
        byte_v = hit_word.b[addr_q[1:0]];
        half_v = addr_q[1] ? {hit_word.b[3], hit_word.b[2]} : {hit_word.b[1], hit_word.b[0]};
        case (write_type_q)
            SIZE_BYTE: load_word.w = {{24{signed_ext_q & byte_v[7]}}, byte_v};
            SIZE_HALF: load_word.w = {{16{signed_ext_q & half_v[15]}}, half_v};
            SIZE_WORD: load_word   = hit_word;
            default:   load_word.w = '0;
        endcase
    end

    always_comb begin
        wsel        = '0;
        we_c        = '0;
        wdata_c     = '0;
        tag_we_c    = 1'b0;
        dirty_we_c  = 1'b0;
        dirty_val_c = 1'b0;
        if (lookup_hit && op_q) begin
            wsel           = hits;
            we_c[word_off] = 1'b1;
            wdata_c        = {WORDS_PER_LINE{store_word}};
            dirty_we_c     = 1'b1;
            dirty_val_c    = 1'b1;
        end else if (state == S_INSTALL) begin
            wsel       = victim_q;
            we_c       = '1;
            wdata_c    = fill_line;
            tag_we_c   = 1'b1;
            dirty_we_c = 1'b1;
        end
    end

    assign accept       = (state == S_IDLE) && valid;
    assign cache_ready  = (state == S_IDLE);
    assign r_req        = (state == S_RF_REQ);
    assign r_addr       = {addr_q[31:4], 4'b0000};
    assign r_data_ready = (state == S_RF_COLL);
    assign w_req        = (state == S_WB_REQ);
    assign w_addr       = {vic_tag, set_idx, 4'b0000};
    assign w_data_req   = (state == S_WB_DATA);
    assign w_last       = (state == S_WB_DATA) && (wb_cnt == 2'd3);
    assign w_data_mem   = vic_line[wb_cnt].w;

    a_hit_onehot: assert property (@(posedge clk) disable iff (rst)
        state == S_LOOKUP |-> $onehot0(hits));

    a_no_idle_valid: assert property (@(posedge clk) disable iff (rst)
        data_valid |-> state != S_IDLE);

endmodule

`default_nettype wire

//--- source/dcache_top.sv
`default_nettype none

module dcache_top #(
    parameter int SETS_LOG2 = 6
) (
    input  logic        clk,
    input  logic        rst,
    // cpu side
    input  logic        valid,
    input  logic        op,
    input  logic [31:0] addr,
    input  logic [3:0]  write_type,
    input  logic [31:0] w_data_cpu,
    input  logic        signed_ext,
    output logic        cache_ready,
    output logic        data_valid,
    output logic [31:0] r_data_cpu,
    // line refill
    output logic        r_req,
    output logic [31:0] r_addr,
    output logic        r_data_ready,
    input  logic        r_rdy,
    input  logic        ret_valid,
    input  logic        ret_last,
    input  logic [31:0] r_data_mem,
    // dirty writeback
    output logic        w_req,
    output logic [31:0] w_addr,
    output logic        w_data_req,
    output logic        w_last,
    output logic [31:0] w_data_mem,
    input  logic        w_rdy,
    input  logic        w_data_ready
);
    import dcache_pkg::*;

    logic        accept;
    logic [31:0] addr_q;
    logic        op_q;
    logic [3:0]  write_type_q;
    logic        signed_ext_q;
    word_t       store_word;
    word_t       hit_word;

    dcache_way_if #(.SETS_LOG2(SETS_LOG2)) way_bus [NUM_WAYS] ();

    dcache_req_buf #(.SETS_LOG2(SETS_LOG2)) u_req_buf (
        .clk          (clk),
        .rst          (rst),
        .accept       (accept),
        .addr         (addr),
        .op           (op),
        .write_type   (write_type),
        .w_data_cpu   (w_data_cpu),
        .signed_ext   (signed_ext),
        .hit_word     (hit_word),
        .addr_q       (addr_q),
        .op_q         (op_q),
        .write_type_q (write_type_q),
        .signed_ext_q (signed_ext_q),
        .store_word   (store_word),
        .ways         (way_bus)
    );

    for (genvar g = 0; g < NUM_WAYS; g++) begin : g_way
        dcache_way #(.SETS_LOG2(SETS_LOG2)) u_way (
            .clk (clk),
            .rst (rst),
            .wif (way_bus[g])
        );
    end

    dcache_ctrl #(.SETS_LOG2(SETS_LOG2)) u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .valid        (valid),
        .addr_q       (addr_q),
        .op_q         (op_q),
        .write_type_q (write_type_q),
        .signed_ext_q (signed_ext_q),
        .store_word   (store_word),
        .r_rdy        (r_rdy),
        .ret_valid    (ret_valid),
        .ret_last     (ret_last),
        .r_data_mem   (r_data_mem),
        .w_rdy        (w_rdy),
        .w_data_ready (w_data_ready),
        .accept       (accept),
        .hit_word     (hit_word),
        .cache_ready  (cache_ready),
        .data_valid   (data_valid),
        .r_data_cpu   (r_data_cpu),
        .r_req        (r_req),
        .r_addr       (r_addr),
        .r_data_ready (r_data_ready),
        .w_req        (w_req),
        .w_addr       (w_addr),
        .w_data_req   (w_data_req),
        .w_last       (w_last),
        .w_data_mem   (w_data_mem),
        .ways         (way_bus)
    );

endmodule

`default_nettype wire

//--- tests/dcache_mem_model.sv
`default_nettype none

module dcache_mem_model (
    input  logic              clk,
    input  logic              rst,
    input  logic              r_req,
    input  logic [31:0]       r_addr,
    input  logic              r_data_ready,
    output logic              r_rdy,
    output logic              ret_valid,
    output logic              ret_last,
    output logic [31:0]       r_data_mem,
    input  logic              w_req,
    input  logic [31:0]       w_addr,
    input  logic              w_data_req,
    input  logic              w_last,
    input  logic [31:0]       w_data_mem,
    output logic              w_rdy,
    output logic              w_data_ready,
    output dcache_pkg::line_t wb_line,
    output logic [31:0]       wb_addr,
    output int                wb_count,
    output logic              wb_last_ok,
    output int                proto_errs
);
    import dcache_pkg::*;

    localparam int          MEM_WORDS   = 4096;
    localparam int          DRIVE_DELAY = 2;
    localparam logic [31:0] FILL_KEY    = 32'h5a5a_0000;

    logic [31:0] mem [MEM_WORDS];

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #DRIVE_DELAY;
        end
    endtask

    task automatic serve_read();
        logic [9:0] line_idx;
        line_idx = r_addr[13:4];
        idle_cycles($urandom_range(3, 0));
        r_rdy = 1'b1;
        @(posedge clk);
        #DRIVE_DELAY;
        r_rdy = 1'b0;
        // lowest word first
        for (int i = 0; i < WORDS_PER_LINE; i++) begin
            idle_cycles($urandom_range(3, 0));
            if (!r_data_ready) begin
                $display("r_data_ready was low when refill word %0d was returned at %0t",
                         i, $time);
                proto_errs++;
            end
            ret_valid  = 1'b1;
            ret_last   = (i == WORDS_PER_LINE - 1);
            r_data_mem = mem[{line_idx, 2'(i)}];
            @(posedge clk);
            #DRIVE_DELAY;
            ret_valid = 1'b0;
            ret_last  = 1'b0;
        end
    endtask

    task automatic serve_write();
        logic [9:0]  line_idx;
        logic [31:0] addr_cap;
        line_t       cur;
        logic        last_ok;
        line_idx = w_addr[13:4];
        addr_cap = w_addr;
        last_ok  = 1'b1;
        idle_cycles($urandom_range(3, 0));
        w_rdy = 1'b1;
        @(posedge clk);
        #DRIVE_DELAY;
        w_rdy = 1'b0;
        for (int i = 0; i < WORDS_PER_LINE; i++) begin
            idle_cycles($urandom_range(3, 0));
            if (!w_data_req) begin
                $display("w_data_req was low when writeback word %0d was taken at %0t",
                         i, $time);
                proto_errs++;
            end
            cur[i].w = w_data_mem;
            if (w_last != (i == WORDS_PER_LINE - 1)) begin
                last_ok = 1'b0;
            end
            w_data_ready = 1'b1;
            @(posedge clk);
            #DRIVE_DELAY;
            w_data_ready = 1'b0;
            mem[{line_idx, 2'(i)}] = cur[i].w;
        end
        wb_line    = cur;
        wb_addr    = addr_cap;
        wb_last_ok = last_ok;
        wb_count++;
    endtask

    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = i ^ FILL_KEY;
        end
        r_rdy        = 1'b0;
        ret_valid    = 1'b0;
        ret_last     = 1'b0;
        r_data_mem   = '0;
        w_rdy        = 1'b0;
        w_data_ready = 1'b0;
        wb_line      = '0;
        wb_addr      = '0;
        wb_count     = 0;
        wb_last_ok   = 1'b0;
        proto_errs   = 0;
        forever begin
            @(posedge clk);
            #DRIVE_DELAY;
            if (!rst && r_req) begin
                serve_read();
            end else if (!rst && w_req) begin
                serve_write();
            end
        end
    end

endmodule

`default_nettype wire

//--- tests/dcache_tb.sv
`default_nettype none

module dcache_tb;
    import dcache_pkg::*;

    localparam int SETS_LOG2   = 6;
    localparam int DRIVE_DELAY = 2;
    localparam int WAIT_LIMIT  = 200;
    localparam int HIT_CYCLES  = 2;

    logic        clk;
    logic        rst;
    logic        valid;
    logic        op;
    logic [31:0] addr;
    logic [3:0]  write_type;
    logic [31:0] w_data_cpu;
    logic        signed_ext;
    logic        cache_ready;
    logic        data_valid;
    logic [31:0] r_data_cpu;
    logic        r_req;
    logic [31:0] r_addr;
    logic        r_data_ready;
    logic        r_rdy;
    logic        ret_valid;
    logic        ret_last;
    logic [31:0] r_data_mem;
    logic        w_req;
    logic [31:0] w_addr;
    logic        w_data_req;
    logic        w_last;
    logic [31:0] w_data_mem;
    logic        w_rdy;
    logic        w_data_ready;

    line_t       wb_line;
    logic [31:0] wb_addr;
    int          wb_count;
    logic        wb_last_ok;
    int          proto_errs;

    int          tests_run;
    int          tests_failed;
    int          wb_seen;
    bit          test_ok;
    bit          aborted;

    dcache_top #(.SETS_LOG2(SETS_LOG2)) u_dcache_top (
        .clk(clk), .rst(rst), .valid(valid), .op(op), .addr(addr),
        .write_type(write_type), .w_data_cpu(w_data_cpu), .signed_ext(signed_ext),
        .cache_ready(cache_ready), .data_valid(data_valid), .r_data_cpu(r_data_cpu),
        .r_req(r_req), .r_addr(r_addr), .r_data_ready(r_data_ready), .r_rdy(r_rdy),
        .ret_valid(ret_valid), .ret_last(ret_last), .r_data_mem(r_data_mem),
        .w_req(w_req), .w_addr(w_addr), .w_data_req(w_data_req), .w_last(w_last),
        .w_data_mem(w_data_mem), .w_rdy(w_rdy), .w_data_ready(w_data_ready)
    );

    dcache_mem_model u_mem_model (
        .clk(clk), .rst(rst), .r_req(r_req), .r_addr(r_addr),
        .r_data_ready(r_data_ready), .r_rdy(r_rdy), .ret_valid(ret_valid),
        .ret_last(ret_last), .r_data_mem(r_data_mem), .w_req(w_req), .w_addr(w_addr),
        .w_data_req(w_data_req), .w_last(w_last), .w_data_mem(w_data_mem),
        .w_rdy(w_rdy), .w_data_ready(w_data_ready), .wb_line(wb_line),
        .wb_addr(wb_addr), .wb_count(wb_count), .wb_last_ok(wb_last_ok),
        .proto_errs(proto_errs)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    task automatic check_word(input word_t got, input word_t exp_val, input string what);
        if (got !== exp_val) begin
            $display("** Error at %0t: %s returned %08h, expected %08h",
                     $time, what, got.w, exp_val.w);
            test_ok = 1'b0;
        end
    endtask

    task automatic check_line(input line_t got, input line_t exp_val, input string what);
        if (got !== exp_val) begin
            $display("** Error at %0t: %s held %032h, expected %032h",
                     $time, what, got, exp_val);
            test_ok = 1'b0;
        end
    endtask

    task automatic check_cycles(input int got, input int exp_val, input string what);
        if (got != exp_val) begin
            $display("** Error at %0t: %s was %0d cycles, expected %0d",
                     $time, what, got, exp_val);
            test_ok = 1'b0;
        end
    endtask

    task automatic wait_ready(output bit ok);
        int n;
        n  = 0;
        ok = 1'b1;
        while (!cache_ready && ok) begin
            @(posedge clk);
            #DRIVE_DELAY;
            n++;
            if (n > WAIT_LIMIT) begin
                $display("timeout: cache_ready never went high at %0t", $time);
                ok = 1'b0;
            end
        end
    endtask

    // cache_ready has to stay low for the whole access
    task automatic wait_result(output bit ok, output int cycles);
        ok     = 1'b1;
        cycles = 0;
        do begin
            @(posedge clk);
            #DRIVE_DELAY;
            cycles++;
            if (cache_ready) begin
                $display("cache_ready was high before data_valid at %0t", $time);
                test_ok = 1'b0;
            end
            if (!data_valid && cycles > WAIT_LIMIT) begin
                $display("timeout: data_valid never arrived at %0t", $time);
                ok = 1'b0;
            end
        end while (!data_valid && ok);
    endtask

    task automatic do_access(input logic [7:0] kind, input logic [31:0] a,
                             input logic [31:0] data, input logic [3:0] mask,
                             input logic sign, input logic [31:0] expect_val);
        bit ok;
        int cycles;
        wait_ready(ok);
        if (!ok) begin
            aborted = 1'b1;
            test_ok = 1'b0;
        end else begin
            valid      = 1'b1;
            op         = (kind == "S");
            addr       = a;
            write_type = mask;
            w_data_cpu = data;
            signed_ext = sign;
            @(posedge clk);
            #DRIVE_DELAY;
            valid = 1'b0;
            wait_result(ok, cycles);
            if (!ok) begin
                aborted = 1'b1;
                test_ok = 1'b0;
            end else if (kind != "S") begin
                check_word(word_t'(r_data_cpu), word_t'(expect_val), "load");
                if (kind == "H") begin
                    check_cycles(cycles, HIT_CYCLES, "hit latency");
                end
            end
        end
    endtask

    task automatic check_writeback(input logic [31:0] a, input line_t exp_line);
        if (wb_count == wb_seen) begin
            $display("no new line writeback was seen before %0t", $time);
            test_ok = 1'b0;
        end else begin
            check_word(word_t'(wb_addr), word_t'(a), "writeback address");
            check_line(wb_line, exp_line, "writeback line");
            if (!wb_last_ok) begin
                $display("w_last was not high with only the fourth word at %0t", $time);
                test_ok = 1'b0;
            end
        end
        wb_seen = wb_count;
    endtask

    initial begin
        int          fd;
        int          n;
        string       line;
        logic [7:0]  op_c;
        logic [31:0] f_addr;
        logic [31:0] f_a;
        logic [31:0] f_b;
        logic [31:0] f_c;
        logic [31:0] f_d;
        line_t       exp_line;
        void'($urandom(57382));
        rst          = 1'b1;
        valid        = 1'b0;
        op           = 1'b0;
        addr         = '0;
        write_type   = '0;
        w_data_cpu   = '0;
        signed_ext   = 1'b0;
        tests_run    = 0;
        tests_failed = 0;
        wb_seen      = 0;
        aborted      = 1'b0;
        repeat (4) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;
        fd = $fopen("tests/dcache_testdata.txt", "r");
        if (fd == 0) begin
            $display("could not open tests/dcache_testdata.txt");
            aborted = 1'b1;
        end else begin
            while (!aborted && $fgets(line, fd) > 0) begin
                if (line.len() > 1 && line[0] != "#") begin
                    test_ok = 1'b1;
                    n = $sscanf(line, "%c %h %h %h %h %h", op_c, f_addr, f_a, f_b, f_c, f_d);
                    if (n != 6) begin
                        $display("malformed data file line: %s", line);
                        test_ok = 1'b0;
                    end else if (op_c == "W") begin
                        exp_line[0].w = f_a;
                        exp_line[1].w = f_b;
                        exp_line[2].w = f_c;
                        exp_line[3].w = f_d;
                        check_writeback(f_addr, exp_line);
                    end else if (op_c == "L" || op_c == "H" || op_c == "S") begin
                        do_access(op_c, f_addr, f_a, f_b[3:0], f_c[0], f_d);
                    end else begin
                        $display("unknown operation %c in data file", op_c);
                        test_ok = 1'b0;
                    end
                    tests_run++;
                    if (!test_ok) begin
                        tests_failed++;
                    end
                    $display("test %0d %c %08h: %s", tests_run, op_c, f_addr,
                             test_ok ? "ok" : "FAILED");
                end
            end
            $fclose(fd);
        end
        if (proto_errs != 0) begin
            $display("memory model saw %0d handshake violations", proto_errs);
        end
        $display("%0d tests run, %0d failed", tests_run, tests_failed);
        if (tests_failed == 0 && !aborted && proto_errs == 0 && tests_run > 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
source/dcache_pkg.sv
source/dcache_way_if.sv
source/dcache_req_buf.sv
source/dcache_way.sv
source/dcache_ctrl.sv
source/dcache_top.sv
tests/dcache_mem_model.sv
tests/dcache_tb.sv

//--- Makefile
VERILATOR ?= verilator
FILELIST  ?= sources.f
TB_TOP    ?= dcache_tb
RTL_TOP   ?= dcache_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing
LINTFLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)

run: build
	$(BUILD_DIR)/V$(TB_TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Test failures found" $(LOG); then exit 1; fi

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tests/dcache_testdata.txt
# op addr a b c d : L and H loads (H must hit in 2 cycles), S stores, a=store data,
# b=byte mask or load size, c=sign flag, d=expected load; W checks last writeback, a..d=words 0-3
L 00000040 00000000 f 0 5a5a0010
H 00000044 00000000 f 0 5a5a0011
H 0000004c 00000000 f 0 5a5a0013
S 00000048 00c30000 4 0 00000000
H 00000048 00000000 f 0 5ac30012
H 0000004a 00000000 1 1 ffffffc3
H 0000004a 00000000 1 0 000000c3
H 0000004a 00000000 3 1 00005ac3
H 00000049 00000000 1 1 00000000
S 00000044 00009876 3 0 00000000
H 00000044 00000000 3 1 ffff9876
H 00000044 00000000 3 0 00009876
H 00000045 00000000 1 1 ffffff98
H 00000046 00000000 3 1 00005a5a
L 00000440 00000000 f 0 5a5a0110
L 00000840 00000000 f 0 5a5a0210
L 00000c40 00000000 f 0 5a5a0310
L 00001040 00000000 f 0 5a5a0410
W 00000040 5a5a0010 5a5a9876 5ac30012 5a5a0013
L 00000048 00000000 f 0 5ac30012
H 00000044 00000000 3 1 ffff9876
S 00000104 de000000 8 0 00000000
H 00000104 00000000 f 0 de5a0041
H 00000107 00000000 1 1 ffffffde
L 00003ffc 00000000 f 0 5a5a0fff
